// File: l1i_fetch.f
+incdir+rtl
rtl/l1i_pkg.sv
rtl/predecode.sv
rtl/icache_arrays.sv
rtl/fetch_ctrl.sv
rtl/fetch_queue.sv
rtl/l1i_fetch.sv
tb/tb_l1i_fetch.sv

// File: rtl/fetch_ctrl.sv
`timescale 1ns/1ps
`default_nettype none
`include "l1i_macros.svh"

module fetch_ctrl
   import l1i_pkg::*;
   (
   input  wire                            clk,
   input  wire                            reset,
   input  wire                            restart_valid,
   input  wire [`M_WIDTH-1:0]             restart_pc,
   output logic                           restart_ack,
   output logic                           mem_req_valid,
   output logic [`M_WIDTH-1:0]            mem_req_addr,
   input  wire                            mem_rsp_valid,
   output logic [`LG_L1I_NUM_SETS-1:0]    rd_idx,
   input  wire                            rd_valid,
   input  wire [`N_TAG_BITS-1:0]          rd_tag,
   input  wire [`L1I_CL_BITS-1:0]         rd_line,
   input  wire pd_kind_t [`WORDS_PER_CL-1:0] rd_kinds,
   output logic [`M_WIDTH-1:0]            refill_addr,
   output logic                           inval_valid,
   output logic [`LG_L1I_NUM_SETS-1:0]    inval_idx,
   input  wire                            full,
   output logic                           push,
   output fetch_entry_t                   push_entry,
   output logic                           clear
   );

   localparam IDX_START = `LG_L1I_CL_LEN;
   localparam IDX_STOP  = `LG_L1I_CL_LEN + `LG_L1I_NUM_SETS;

   typedef enum logic [2:0] {
      INIT_SWEEP,
      IDLE,
      ACTIVE,
      INJECT_RELOAD,
      RELOAD_TURNAROUND,
      WAIT_FOR_NOT_FULL
   } state_t;

   state_t                       r_state, n_state;
   logic [`M_WIDTH-1:0]          r_pc, n_pc;             // next pc to look up
   logic [`M_WIDTH-1:0]          r_cache_pc, n_cache_pc; // pc of the lookup in flight
   logic [`M_WIDTH-1:0]          r_miss_pc, n_miss_pc;   // replay point
   logic [`M_WIDTH-1:0]          r_mem_req_addr, n_mem_req_addr;
   logic                         r_mem_req_valid, n_mem_req_valid;
   logic                         r_req, n_req;
   logic                         r_delay_slot, n_delay_slot;
   logic                         r_restart_req, n_restart_req;
   logic [`LG_L1I_NUM_SETS-1:0]  r_sweep_idx;

   logic [IDX_START-3:0]         t_word;
   logic [31:0]                  t_insn;
   pd_kind_t                     t_kind;
   logic                         t_hit, t_miss, t_take_br;
   logic [`M_WIDTH-1:0]          t_simm, t_target;

   assign mem_req_valid = r_mem_req_valid;
   assign mem_req_addr  = r_mem_req_addr;
   assign refill_addr   = r_mem_req_addr;
   assign inval_valid   = (r_state == INIT_SWEEP);
   assign inval_idx     = r_sweep_idx;

   // restart is taken in the first cycle it is pending in one of these states
   assign restart_ack = r_restart_req &&
                        (r_state == IDLE || r_state == ACTIVE ||
                         r_state == RELOAD_TURNAROUND || r_state == WAIT_FOR_NOT_FULL);

   // hit check and prediction on the word returned by last cycle's lookup
   always_comb
   begin
      t_word    = r_cache_pc[IDX_START-1:2];
      t_insn    = rd_line[32*t_word +: 32];
      t_kind    = rd_kinds[t_word];
      t_hit     = r_req && rd_valid && (rd_tag == r_cache_pc[`M_WIDTH-1:IDX_STOP]);
      t_miss    = r_req && !t_hit;
      // a delay slot is never predicted itself
      t_take_br = t_hit && !r_delay_slot &&
                  (t_kind == PD_JUMP || t_kind == PD_BRANCH_ALWAYS);
      t_simm    = {{(`M_WIDTH-18){t_insn[15]}}, t_insn[15:0], 2'b00};
      if (t_kind == PD_JUMP)
      begin
         t_target = {r_cache_pc[`M_WIDTH-1:28], t_insn[25:0], 2'b00};
      end
      else
      begin
         t_target = r_cache_pc + 'd4 + t_simm;
      end
   end

   always_comb
   begin
      push_entry.pc          = r_cache_pc;
      push_entry.data        = t_insn;
      push_entry.pred        = t_take_br;
      push_entry.pred_target = t_take_br ? t_target : '0; // zero when not predicted
   end

   always_comb
   begin
      n_state         = r_state;
      n_pc            = r_pc;
      n_cache_pc      = r_cache_pc;
      n_miss_pc       = r_miss_pc;
      n_req           = 1'b0;
      n_delay_slot    = r_delay_slot;
      n_mem_req_valid = 1'b0;
      n_mem_req_addr  = r_mem_req_addr;
      n_restart_req   = restart_ack ? 1'b0 : (r_restart_req | restart_valid);
      rd_idx          = r_pc[IDX_STOP-1:IDX_START];
      push            = 1'b0;
      clear           = 1'b0;
      if (restart_ack)
      begin
         // drop the lookup in flight and empty the queue
         n_state      = ACTIVE;
         n_pc         = restart_pc;
         n_delay_slot = 1'b0;
         clear        = 1'b1;
      end
      else
      begin
         case (r_state)
            INIT_SWEEP:
            begin
               if (&r_sweep_idx)
               begin
                  n_state = IDLE;
               end
            end
            ACTIVE:
            begin
               n_cache_pc = r_pc;
               n_req      = 1'b1;
               n_pc       = r_pc + 'd4;
               if (t_miss)
               begin
                  n_state         = INJECT_RELOAD;
                  n_pc            = r_pc; // successor of the missed word, target after a slot
                  n_mem_req_valid = 1'b1;
                  n_mem_req_addr  = {r_cache_pc[`M_WIDTH-1:IDX_START], {IDX_START{1'b0}}};
                  n_miss_pc       = r_cache_pc;
                  n_req           = 1'b0;
               end
               else if (t_hit && full)
               begin
                  n_state   = WAIT_FOR_NOT_FULL; // replay this word later
                  n_pc      = r_pc;
                  n_miss_pc = r_cache_pc;
                  n_req     = 1'b0;
               end
               else if (t_hit)
               begin
                  push         = 1'b1;
                  n_delay_slot = t_take_br;
                  // the delay slot is already being looked up, go to target after it
                  if (t_take_br)
                  begin
                     n_pc = t_target;
                  end
               end
            end
            INJECT_RELOAD:
            begin
               if (mem_rsp_valid)
               begin
                  n_state = RELOAD_TURNAROUND;
               end
            end
            RELOAD_TURNAROUND, WAIT_FOR_NOT_FULL:
            begin
               rd_idx = r_miss_pc[IDX_STOP-1:IDX_START];
               if (r_state == RELOAD_TURNAROUND || !full)
               begin
                  n_state    = ACTIVE;
                  n_cache_pc = r_miss_pc;
                  n_req      = 1'b1;
               end
            end
            default:
            begin
               n_state = r_state;
            end
         endcase
      end
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         r_state         <= INIT_SWEEP;
         r_sweep_idx     <= '0;
         r_req           <= 1'b0;
         r_delay_slot    <= 1'b0;
         r_restart_req   <= 1'b0;
         r_mem_req_valid <= 1'b0;
      end
      else
      begin
         r_state         <= n_state;
         r_req           <= n_req;
         r_delay_slot    <= n_delay_slot;
         r_restart_req   <= n_restart_req;
         r_mem_req_valid <= n_mem_req_valid;
         if (r_state == INIT_SWEEP)
         begin
            r_sweep_idx <= r_sweep_idx + 1'b1;
         end
      end
   end

   always_ff @(posedge clk)
   begin
      r_pc           <= n_pc;
      r_cache_pc     <= n_cache_pc;
      r_miss_pc      <= n_miss_pc;
      r_mem_req_addr <= n_mem_req_addr;
   end

endmodule

`default_nettype wire

// File: rtl/fetch_queue.sv
`timescale 1ns/1ps
`default_nettype none
`include "l1i_macros.svh"

module fetch_queue
   import l1i_pkg::*;
   (
   input  wire                   clk,
   input  wire                   reset,
   input  wire                   clear,
   input  wire                   push,
   input  wire fetch_entry_t     push_entry,
   input  wire                   insn_ack,
   input  wire                   insn_ack_two,
   output logic                  full,
   output logic                  insn_valid,
   output logic                  insn_valid_two,
   output logic [`M_WIDTH-1:0]   insn_pc,
   output logic [31:0]           insn_data,
   output logic                  insn_pred,
   output logic [`M_WIDTH-1:0]   insn_pred_target,
   output logic [`M_WIDTH-1:0]   insn_pc_two,
   output logic [31:0]           insn_data_two,
   output logic                  insn_pred_two,
   output logic [`M_WIDTH-1:0]   insn_pred_target_two
   );

   localparam N_FQ_ENTRIES = 1 << `LG_FQ_ENTRIES;

   fetch_entry_t               r_fq [N_FQ_ENTRIES-1:0];
   logic [`LG_FQ_ENTRIES:0]    r_head, r_tail; // extra bit tells full from empty
   logic [`LG_FQ_ENTRIES:0]    t_next_head, t_count;
   fetch_entry_t               t_first, t_second;

   assign t_next_head = r_head + 1'b1;
   assign t_count     = r_tail - r_head;

   assign full = (r_head[`LG_FQ_ENTRIES] != r_tail[`LG_FQ_ENTRIES]) &&
                 (r_head[`LG_FQ_ENTRIES-1:0] == r_tail[`LG_FQ_ENTRIES-1:0]);
   assign insn_valid     = (r_head != r_tail);
   assign insn_valid_two = (t_count > 'd1);

   assign t_first  = r_fq[r_head[`LG_FQ_ENTRIES-1:0]];
   assign t_second = r_fq[t_next_head[`LG_FQ_ENTRIES-1:0]];

   assign insn_pc              = t_first.pc;
   assign insn_data            = t_first.data;
   assign insn_pred            = t_first.pred;
   assign insn_pred_target     = t_first.pred_target;
   assign insn_pc_two          = t_second.pc;
   assign insn_data_two        = t_second.data;
   assign insn_pred_two        = t_second.pred;
   assign insn_pred_target_two = t_second.pred_target;

   always_ff @(posedge clk)
   begin
      if (push && !clear)
      begin
         r_fq[r_tail[`LG_FQ_ENTRIES-1:0]] <= push_entry;
      end
   end

   always_ff @(posedge clk)
   begin
      if (reset || clear)
      begin
         r_head <= '0;
         r_tail <= '0;
      end
      else
      begin
         if (push)
         begin
            r_tail <= r_tail + 1'b1;
         end
         if (insn_ack)
         begin
            r_head <= insn_ack_two ? r_head + 2'd2 : t_next_head;
         end
      end
   end

endmodule

`default_nettype wire

// File: rtl/icache_arrays.sv
`timescale 1ns/1ps
`default_nettype none
`include "l1i_macros.svh"

module icache_arrays
   import l1i_pkg::*;
   (
   input  wire                              clk,
   input  wire                              reset,
   input  wire [`LG_L1I_NUM_SETS-1:0]       rd_idx,
   input  wire                              refill_valid,
   input  wire [`M_WIDTH-1:0]               refill_addr,
   input  wire [`L1I_CL_BITS-1:0]           refill_line,
   input  wire                              inval_valid,
   input  wire [`LG_L1I_NUM_SETS-1:0]       inval_idx,
   output logic                             rd_valid,
   output logic [`N_TAG_BITS-1:0]           rd_tag,
   output logic [`L1I_CL_BITS-1:0]          rd_line,
   output pd_kind_t [`WORDS_PER_CL-1:0]     rd_kinds
   );

   localparam NUM_SETS  = 1 << `LG_L1I_NUM_SETS;
   localparam IDX_START = `LG_L1I_CL_LEN;
   localparam IDX_STOP  = `LG_L1I_CL_LEN + `LG_L1I_NUM_SETS;

   logic                           valid_arr [NUM_SETS-1:0];
   logic [`N_TAG_BITS-1:0]         tag_arr [NUM_SETS-1:0];
   logic [`L1I_CL_BITS-1:0]        line_arr [NUM_SETS-1:0];
   pd_kind_t [`WORDS_PER_CL-1:0]   kind_arr [NUM_SETS-1:0];

   logic [`L1I_CL_BITS-1:0]        t_swapped;
   pd_kind_t [`WORDS_PER_CL-1:0]   t_kinds;
   logic [`LG_L1I_NUM_SETS-1:0]    t_refill_idx;

   assign t_refill_idx = refill_addr[IDX_STOP-1:IDX_START];

   // word w of a line sits at bits [32*w +: 32], lowest address in the low lane
   for (genvar w = 0; w < `WORDS_PER_CL; w++)
   begin : g_word
      assign t_swapped[32*w +: 32] = bswap32(refill_line[32*w +: 32]);

      predecode pd_i (
         .insn (t_swapped[32*w +: 32]),
         .kind (t_kinds[w])
      );
   end

   // valid bits, cleared one set at a time by the sweep
   always_ff @(posedge clk)
   begin
      if (inval_valid)
      begin
         valid_arr[inval_idx] <= 1'b0;
      end
      if (refill_valid)
      begin
         valid_arr[t_refill_idx] <= 1'b1;
      end
   end

   always_ff @(posedge clk)
   begin
      if (refill_valid)
      begin
         tag_arr[t_refill_idx]  <= refill_addr[`M_WIDTH-1:IDX_STOP];
         line_arr[t_refill_idx] <= t_swapped;
         kind_arr[t_refill_idx] <= t_kinds;
      end
   end

   // registered read, data one cycle after rd_idx
   always_ff @(posedge clk)
   begin
      rd_valid <= reset ? 1'b0 : valid_arr[rd_idx];
      rd_tag   <= tag_arr[rd_idx];
      rd_line  <= line_arr[rd_idx];
      rd_kinds <= kind_arr[rd_idx];
   end

endmodule

`default_nettype wire

// File: rtl/l1i_fetch.sv
`timescale 1ns/1ps
`default_nettype none
`include "l1i_macros.svh"

module l1i_fetch
   import l1i_pkg::*;
   (
   input  wire                      clk,
   input  wire                      reset,
   input  wire                      restart_valid,
   input  wire [`M_WIDTH-1:0]       restart_pc,
   output logic                     restart_ack,
   output logic                     mem_req_valid,
   output logic [`M_WIDTH-1:0]      mem_req_addr,
   input  wire                      mem_rsp_valid,
   input  wire [`L1I_CL_BITS-1:0]   mem_rsp_load_data,
   output logic                     insn_valid,
   output logic                     insn_valid_two,
   input  wire                      insn_ack,
   input  wire                      insn_ack_two,
   output logic [`M_WIDTH-1:0]      insn_pc,
   output logic [31:0]              insn_data,
   output logic                     insn_pred,
   output logic [`M_WIDTH-1:0]      insn_pred_target,
   output logic [`M_WIDTH-1:0]      insn_pc_two,
   output logic [31:0]              insn_data_two,
   output logic                     insn_pred_two,
   output logic [`M_WIDTH-1:0]      insn_pred_target_two
   );

   logic [`LG_L1I_NUM_SETS-1:0]     rd_idx;
   logic                            rd_valid;
   logic [`N_TAG_BITS-1:0]          rd_tag;
   logic [`L1I_CL_BITS-1:0]         rd_line;
   pd_kind_t [`WORDS_PER_CL-1:0]    rd_kinds;
   logic [`M_WIDTH-1:0]             refill_addr;
   logic                            inval_valid;
   logic [`LG_L1I_NUM_SETS-1:0]     inval_idx;
   logic                            full;
   logic                            push;
   fetch_entry_t                    push_entry;
   logic                            clear;

   fetch_ctrl fetch_ctrl_i (
      .clk           (clk),
      .reset         (reset),
      .restart_valid (restart_valid),
      .restart_pc    (restart_pc),
      .restart_ack   (restart_ack),
      .mem_req_valid (mem_req_valid),
      .mem_req_addr  (mem_req_addr),
      .mem_rsp_valid (mem_rsp_valid),
      .rd_idx        (rd_idx),
      .rd_valid      (rd_valid),
      .rd_tag        (rd_tag),
      .rd_line       (rd_line),
      .rd_kinds      (rd_kinds),
      .refill_addr   (refill_addr),
      .inval_valid   (inval_valid),
      .inval_idx     (inval_idx),
      .full          (full),
      .push          (push),
      .push_entry    (push_entry),
      .clear         (clear)
   );

   // the line is written in the cycle of the memory response
   icache_arrays icache_arrays_i (
      .clk          (clk),
      .reset        (reset),
      .rd_idx       (rd_idx),
      .refill_valid (mem_rsp_valid),
      .refill_addr  (refill_addr),
      .refill_line  (mem_rsp_load_data),
      .inval_valid  (inval_valid),
      .inval_idx    (inval_idx),
      .rd_valid     (rd_valid),
      .rd_tag       (rd_tag),
      .rd_line      (rd_line),
      .rd_kinds     (rd_kinds)
   );

   fetch_queue fetch_queue_i (
      .clk                  (clk),
      .reset                (reset),
      .clear                (clear),
      .push                 (push),
      .push_entry           (push_entry),
      .insn_ack             (insn_ack),
      .insn_ack_two         (insn_ack_two),
      .full                 (full),
      .insn_valid           (insn_valid),
      .insn_valid_two       (insn_valid_two),
      .insn_pc              (insn_pc),
      .insn_data            (insn_data),
      .insn_pred            (insn_pred),
      .insn_pred_target     (insn_pred_target),
      .insn_pc_two          (insn_pc_two),
      .insn_data_two        (insn_data_two),
      .insn_pred_two        (insn_pred_two),
      .insn_pred_target_two (insn_pred_target_two)
   );

endmodule

`default_nettype wire

// File: rtl/l1i_macros.svh
`ifndef L1I_MACROS_SVH
`define L1I_MACROS_SVH

// fetch address width
`define M_WIDTH 32

// cache geometry, direct mapped
`define LG_L1I_NUM_SETS 4
`define LG_L1I_CL_LEN 4
`define L1I_CL_BITS (1 << (`LG_L1I_CL_LEN + 3))
`define WORDS_PER_CL (1 << (`LG_L1I_CL_LEN - 2))
`define N_TAG_BITS (`M_WIDTH - `LG_L1I_NUM_SETS - `LG_L1I_CL_LEN)

// fetch queue depth
`define LG_FQ_ENTRIES 3

`endif

// File: rtl/l1i_pkg.sv
`default_nettype none
`include "l1i_macros.svh"

package l1i_pkg;

   // branch class stored beside each cached word
   typedef enum logic [1:0] {
      PD_NONE          = 2'd0,
      PD_JUMP          = 2'd1, // j, jal
      PD_BRANCH_ALWAYS = 2'd2, // beq $0,$0
      PD_COND          = 2'd3  // kept but never predicted
   } pd_kind_t;

   // one word waiting in the fetch queue
   typedef struct packed {
      logic [`M_WIDTH-1:0] pc;
      logic [31:0]         data;
      logic                pred;
      logic [`M_WIDTH-1:0] pred_target;
   } fetch_entry_t;

   // memory lanes are big endian, the core wants little endian
   function automatic logic [31:0] bswap32(input logic [31:0] w);
      return {w[7:0], w[15:8], w[23:16], w[31:24]};
   endfunction

endpackage

`default_nettype wire

// File: rtl/predecode.sv
`timescale 1ns/1ps
`default_nettype none

module predecode
   import l1i_pkg::*;
   (
   input  wire [31:0] insn, // already byte swapped
   output pd_kind_t   kind
   );

   logic [5:0] op;
   logic [4:0] rs;
   logic [4:0] rt;

   assign op = insn[31:26];
   assign rs = insn[25:21];
   assign rt = insn[20:16];

   always_comb
   begin
      kind = PD_NONE;
      case (op)
         6'd1:
         begin
            // regimm: bltz, bgez, bltzl, bgezl, bgezal
            if (rt <= 5'd3 || rt == 5'd17)
            begin
               kind = PD_COND;
            end
         end
         6'd2, 6'd3:
         begin
            kind = PD_JUMP;
         end
         6'd4:
         begin
            // beq $0,$0 is the usual unconditional branch idiom
            if (rs == 5'd0 && rt == 5'd0)
            begin
               kind = PD_BRANCH_ALWAYS;
            end
            else
            begin
               kind = PD_COND;
            end
         end
         6'd5, 6'd6, 6'd7:
         begin
            kind = PD_COND; // bne, blez, bgtz
         end
         6'd20, 6'd21, 6'd22, 6'd23:
         begin
            kind = PD_COND; // likely variants
         end
         default:
         begin
            kind = PD_NONE;
         end
      endcase
   end

endmodule

`default_nettype wire

// File: tb/tb_l1i_fetch.sv
`timescale 1ns/1ps
`default_nettype none
`include "l1i_macros.svh"

module tb_l1i_fetch;

   localparam N_WORDS         = 2000;
   localparam N_RESTARTS      = 8;
   localparam WATCHDOG_CYCLES = 40 * N_WORDS;
   localparam FQ_ENTRIES      = 1 << `LG_FQ_ENTRIES;
   localparam logic [31:0] SEED = 32'h16e8_7799;

   logic                      clk;
   logic                      reset;
   logic                      restart_valid;
   logic [`M_WIDTH-1:0]       restart_pc;
   logic                      restart_ack;
   logic                      mem_req_valid;
   logic [`M_WIDTH-1:0]       mem_req_addr;
   logic                      mem_rsp_valid;
   logic [`L1I_CL_BITS-1:0]   mem_rsp_load_data;
   logic                      insn_valid, insn_valid_two;
   logic                      insn_ack, insn_ack_two;
   logic [`M_WIDTH-1:0]       insn_pc, insn_pc_two;
   logic [31:0]               insn_data, insn_data_two;
   logic                      insn_pred, insn_pred_two;
   logic [`M_WIDTH-1:0]       insn_pred_target, insn_pred_target_two;

   logic [31:0] con_seed, mem_seed;
   int          errors = 0;
   int          words = 0;
   int          restarts = 0;
   int          next_restart_at = 0;
   int          mem_wait = 0;
   logic        go = 1'b0;
   logic        done = 1'b0;
   logic        pending = 1'b0;
   logic        mem_busy = 1'b0;
   logic        exp_ds = 1'b0;       // next expected word is a delay slot
   logic [31:0] exp_pc = '0;
   logic [31:0] exp_tgt = '0;
   logic [31:0] mem_addr = '0;

   l1i_fetch l1i_fetch_i (.*);

   function automatic logic [31:0] xorshift(input logic [31:0] x);
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   // instruction at a word address, a fixed hash of the address
   function automatic logic [31:0] mem_word(input logic [31:0] addr);
      logic [31:0] h;
      logic [31:0] r;
      h = xorshift(xorshift({addr[31:2], 2'b00} ^ 32'h5bd1_e995));
      r = xorshift(h ^ 32'h2545_f491);
      case (h[3:0])
         4'd0, 4'd1: return {6'd2, r[25:0]};                      // j
         4'd2:       return {6'd3, r[25:0]};                      // jal
         4'd3, 4'd4: return {6'd4, 10'd0, {8{r[7]}}, r[7:0]};     // beq $0,$0
         4'd5, 4'd6: return {6'd5, r[25:0]};                      // bne
         default:    return {6'd0, r[25:0]};
      endcase
   endfunction

   function automatic logic [31:0] byte_reverse(input logic [31:0] w);
      return {w[7:0], w[15:8], w[23:16], w[31:24]};
   endfunction

   // memory lanes hold big-endian words, lowest address in the low lane
   function automatic logic [`L1I_CL_BITS-1:0] mem_line(input logic [31:0] addr);
      logic [`L1I_CL_BITS-1:0] line;
      for (int w = 0; w < `WORDS_PER_CL; w++)
      begin
         line[32*w +: 32] = byte_reverse(mem_word(addr + 4*w));
      end
      return line;
   endfunction

   // j, jal and beq $0,$0 outside a delay slot are predicted taken
   function automatic logic predicted(input logic [31:0] d, input logic in_ds);
      logic is_jmp;
      logic is_br;
      is_jmp = (d[31:26] == 6'd2) || (d[31:26] == 6'd3);
      is_br  = (d[31:26] == 6'd4) && (d[25:21] == 5'd0) && (d[20:16] == 5'd0);
      return (is_jmp || is_br) && !in_ds;
   endfunction

   function automatic logic [31:0] branch_target(input logic [31:0] pc, input logic [31:0] d);
      logic [31:0] t;
      if ((d[31:26] == 6'd2) || (d[31:26] == 6'd3))
      begin
         t = {pc[31:28], d[25:0], 2'b00};
      end
      else
      begin
         t = pc + 32'd4 + {{14{d[15]}}, d[15:0], 2'b00};
      end
      return t;
   endfunction

   // one step of the expected stream, the target follows the delay slot
   task automatic advance(inout logic [31:0] pc, inout logic ds, inout logic [31:0] tgt);
      logic [31:0] d;
      d = mem_word(pc);
      if (predicted(d, ds))
      begin
         ds  = 1'b1;
         tgt = branch_target(pc, d);
         pc  = pc + 32'd4;
      end
      else if (ds)
      begin
         ds = 1'b0;
         pc = tgt;
      end
      else
      begin
         pc = pc + 32'd4;
      end
   endtask

   // a missed word sits behind at most a full queue of unpopped words
   task automatic line_on_path(input logic [31:0] addr, output logic found);
      logic [31:0] pc;
      logic [31:0] tgt;
      logic        ds;
      pc    = exp_pc;
      tgt   = exp_tgt;
      ds    = exp_ds;
      found = 1'b0;
      for (int i = 0; i <= FQ_ENTRIES; i++)
      begin
         if (pc[31:`LG_L1I_CL_LEN] == addr[31:`LG_L1I_CL_LEN])
         begin
            found = 1'b1;
         end
         advance(pc, ds, tgt);
      end
   endtask

   // compare one popped word with the expected stream and step the model
   task automatic check_pop(input logic [31:0] pc, input logic [31:0] data,
                            input logic pred, input logic [31:0] tgt);
      logic [31:0] d;
      logic [31:0] t;
      logic        take;
      d    = mem_word(exp_pc);
      take = predicted(d, exp_ds);
      t    = branch_target(exp_pc, d);
      if (pc !== exp_pc || data !== d)
      begin
         errors++;
         $display("mismatch at %0t: pc %h data %h, expected pc %h data %h",
                  $time, pc, data, exp_pc, d);
      end
      if (pred !== take || (take && tgt !== t))
      begin
         errors++;
         $display("mismatch at %0t: pc %h pred %b target %h, expected pred %b target %h",
                  $time, pc, pred, tgt, take, t);
      end
      words++;
      advance(exp_pc, exp_ds, exp_tgt);
   endtask

   initial
   begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // outputs stay quiet from reset until the first restart
   always @(posedge clk)
   begin
      if (!reset && !go &&
          (insn_valid || insn_valid_two || mem_req_valid || restart_ack))
      begin
         errors++;
         $display("outputs active at %0t before the first restart", $time);
      end
   end

   // memory model, one request at a time, 1 to 8 cycles of latency
   always @(posedge clk)
   begin
      mem_rsp_valid <= 1'b0;
      if (reset)
      begin
         mem_busy = 1'b0;
      end
      else if (mem_req_valid)
      begin
         if (mem_req_addr[`LG_L1I_CL_LEN-1:0] != '0)
         begin
            errors++;
            $display("memory request at %0t with unaligned address %h", $time, mem_req_addr);
         end
         if (mem_busy)
         begin
            errors++;
            $display("memory request at %0t while another one is outstanding", $time);
         end
         mem_busy = 1'b1;
         mem_addr = mem_req_addr;
         mem_seed = xorshift(mem_seed);
         mem_wait = 1 + mem_seed[2:0];
      end
      else if (mem_busy)
      begin
         mem_wait--;
         if (mem_wait == 0)
         begin
            mem_rsp_valid     <= 1'b1;
            mem_rsp_load_data <= mem_line(mem_addr);
            mem_busy = 1'b0;
         end
      end
   end

   // consumer, restart source and reference model
   always @(posedge clk)
   begin : consumer
      logic [31:0] r;
      logic        found;
      if (go && !done)
      begin
         if (restart_ack)
         begin
            if (!pending)
            begin
               errors++;
               $display("restart_ack at %0t without a pending restart", $time);
            end
            exp_pc  = restart_pc;
            exp_ds  = 1'b0;
            pending = 1'b0;
            restarts++;
            restart_valid <= 1'b0;
            insn_ack      <= 1'b0;   // queue is cleared at this edge
            insn_ack_two  <= 1'b0;
         end
         else
         begin
            // the requested line must hold the word the fetch unit pushes next
            if (mem_req_valid)
            begin
               line_on_path(mem_req_addr, found);
               if (!found)
               begin
                  errors++;
                  $display("memory request at %0t for line %h off the expected path",
                           $time, mem_req_addr);
               end
            end
            if (insn_ack)
            begin
               if (!insn_valid)
               begin
                  errors++;
                  $display("pop at %0t from an empty queue", $time);
               end
               check_pop(insn_pc, insn_data, insn_pred, insn_pred_target);
               if (insn_ack_two)
               begin
                  check_pop(insn_pc_two, insn_data_two, insn_pred_two, insn_pred_target_two);
               end
            end
            con_seed = xorshift(con_seed);
            r = con_seed;
            // pop only after an idle cycle, so occupancy cannot have dropped
            if (insn_ack || r[1:0] == 2'd0)
            begin
               insn_ack     <= 1'b0;
               insn_ack_two <= 1'b0;
            end
            else
            begin
               insn_ack     <= insn_valid;
               insn_ack_two <= insn_valid && insn_valid_two && r[2];
            end
            if (!pending && restarts < N_RESTARTS && words >= next_restart_at)
            begin
               pending = 1'b1;
               restart_valid <= 1'b1;
               restart_pc    <= {16'h0000, r[17:4], 2'b00};
               next_restart_at = words + 180 + r[31:25];
            end
            if (restarts == N_RESTARTS && words >= N_WORDS)
            begin
               done = 1'b1;
               insn_ack     <= 1'b0;
               insn_ack_two <= 1'b0;
            end
         end
      end
   end

   initial
   begin
      con_seed          = SEED;
      mem_seed          = xorshift(SEED ^ 32'h0000_0001);
      reset             = 1'b1;
      restart_valid     = 1'b0;
      restart_pc        = '0;
      mem_rsp_valid     = 1'b0;
      mem_rsp_load_data = '0;
      insn_ack          = 1'b0;
      insn_ack_two      = 1'b0;
      repeat (5) @(posedge clk);
      reset <= 1'b0;
      repeat (40) @(posedge clk);  // sweep plus some idle cycles
      go <= 1'b1;
      wait (done);
      repeat (2) @(posedge clk);
      $display("errors: %0d, words checked: %0d, restarts: %0d", errors, words, restarts);
      if (errors == 0)
      begin
         $display("Test completed successfully");
      end
      else
      begin
         $display("Test failed");
      end
      $finish;
   end

   initial
   begin
      repeat (WATCHDOG_CYCLES + 100) @(posedge clk);
      $display("timeout: only %0d of %0d words checked, errors: %0d", words, N_WORDS, errors);
      $display("Test failed");
      $finish;
   end

endmodule

`default_nettype wire
